// File: Bender.yml
package:
  name: bf16_block_quantizer

sources:
  # Design, in compile order
  - files:
      - common/bfq_pkg.sv
      - design/bf16_max_tree/bf16_max_tree.sv
      - design/block_exponent_stage.sv
      - design/block_quant/element_quantizer.sv
      - design/block_quant/block_quant_stage.sv
      - design/bf16_block_quantizer.sv

  # Testbench
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_bf16_block_quantizer.sv

// File: common/bfq_pkg.sv
// ----------------------------------------
// BF16 block quantizer shared definitions
// Vector types, the per-block info struct
// and the BF16 field helpers
// ----------------------------------------
package bfq_pkg;

        // ----------------------------------------
        // Vector types
        // ----------------------------------------

        // Sign, 8-bit biased exponent, 7-bit mantissa
        typedef logic [15:0] bf16_t;

        // Biased exponent field alone
        typedef logic [7:0] bf16_exp_t;

        // Quantized element, two's complement
        typedef logic signed [7:0] q_elem_t;

        // Side info that travels with a block
        typedef struct packed {
                bf16_exp_t shared_exp;
                logic      all_zero;
                logic      has_nan;
        } block_info_t;

        // ----------------------------------------
        // Field helpers
        // ----------------------------------------

        // All-ones exponent with non-zero mantissa
        function automatic logic bf16_is_nan(input bf16_t v);
                return (v[14:7] == 8'hff) && (v[6:0] != 7'h00);
        endfunction

        // Zero exponent, subnormals included
        function automatic logic bf16_is_zero(input bf16_t v);
                return v[14:7] == 8'h00;
        endfunction

        // Magnitude with sign dropped, orders like the real value
        function automatic logic [14:0] bf16_mag(input bf16_t v);
                return v[14:0];
        endfunction

endpackage : bfq_pkg

// File: design/bf16_block_quantizer.sv
// ----------------------------------------
// BF16 block quantizer top
// Shared exponent stage followed by the
// INT8 quantization stage, 3 cycles in
// total, one block per cycle
// ----------------------------------------
`timescale 1ns/10ps

module bf16_block_quantizer
        import bfq_pkg::*;
#(
        parameter  int NUM_ELEMS = 8,
        localparam int IDX_W     = $clog2(NUM_ELEMS)
) (
        input  logic                    i_clk,
        input  logic                    i_arst_n,
        input  logic                    i_valid,
        input  bf16_t [NUM_ELEMS-1:0]   i_block,
        output logic                    o_valid,
        output q_elem_t [NUM_ELEMS-1:0] o_q_block,
        output block_info_t             o_info,
        output logic [IDX_W-1:0]        o_max_index
);

        // Between the stages, all registered
        logic                  exp_valid;
        bf16_t [NUM_ELEMS-1:0] exp_block;
        block_info_t           exp_info;
        logic [IDX_W-1:0]      exp_max_index;

        // Edges 1 and 2
        block_exponent_stage #(
                .NUM_ELEMS   (NUM_ELEMS)
        ) u_exp_stage (
                .i_clk       (i_clk),
                .i_arst_n    (i_arst_n),
                .i_valid     (i_valid),
                .i_block     (i_block),
                .o_valid     (exp_valid),
                .o_block     (exp_block),
                .o_info      (exp_info),
                .o_max_index (exp_max_index)
        );

        // Edge 3
        block_quant_stage #(
                .NUM_ELEMS   (NUM_ELEMS)
        ) u_quant_stage (
                .i_clk       (i_clk),
                .i_arst_n    (i_arst_n),
                .i_valid     (exp_valid),
                .i_block     (exp_block),
                .i_info      (exp_info),
                .i_max_index (exp_max_index),
                .o_valid     (o_valid),
                .o_q_block   (o_q_block),
                .o_info      (o_info),
                .o_max_index (o_max_index)
        );

endmodule : bf16_block_quantizer

// File: design/bf16_max_tree/bf16_max_tree.sv
// ----------------------------------------
// BF16 max-magnitude reduction tree
// Pairwise compare over log2(N) levels
// where a NaN wins and ties go to the
// lower index, plus all-zero detection
// ----------------------------------------
`timescale 1ns/10ps

module bf16_max_tree
        import bfq_pkg::*;
#(
        parameter  int NUM_ELEMS = 8,
        localparam int IDX_W     = $clog2(NUM_ELEMS)
) (
        input  bf16_t [NUM_ELEMS-1:0] i_values,
        output bf16_t                 o_max,
        output logic [IDX_W-1:0]      o_max_index,
        output logic                  o_all_zero
);

        // One level per index bit
        localparam int NUM_LEVELS = IDX_W;

        // Leaves plus internal nodes with the root last
        localparam int NUM_NODES = 2*NUM_ELEMS - 1;

        // Flat node storage
        // Level lv starts at 2N - (2N >> lv)
        bf16_t                node_val [NUM_NODES];
        logic [IDX_W-1:0]     node_idx [NUM_NODES];
        logic [NUM_ELEMS-1:0] elem_zero;

        // Winner dominates the whole block
        logic                 max_is_bound;

        // ----------------------------------------
        // Leaves
        // ----------------------------------------
        for (genvar i = 0; i < NUM_ELEMS; i++) begin : gen_leaf
                assign node_val[i]  = i_values[i];
                assign node_idx[i]  = IDX_W'(i);
                // Subnormals count as zero here
                assign elem_zero[i] = bf16_is_zero(i_values[i]);
        end

        assign o_all_zero = &elem_zero;

        // ----------------------------------------
        // Compare levels
        // ----------------------------------------
        for (genvar lv = 1; lv <= NUM_LEVELS; lv++) begin : gen_level
                // First node of the level below
                localparam int SRC = 2*NUM_ELEMS - ((2*NUM_ELEMS) >> (lv - 1));
                // First node of this level
                localparam int DST = 2*NUM_ELEMS - ((2*NUM_ELEMS) >> lv);

                for (genvar n = 0; n < (NUM_ELEMS >> lv); n++) begin : gen_node
                        bf16_t left_val;
                        bf16_t right_val;
                        logic  left_wins;

                        // Left child always holds the lower indices
                        assign left_val  = node_val[SRC + 2*n];
                        assign right_val = node_val[SRC + 2*n + 1];

                        // NaN first then magnitude, and >= keeps the low index on a tie
                        assign left_wins = bf16_is_nan(left_val) |
                                           (~bf16_is_nan(right_val) &
                                            (bf16_mag(left_val) >= bf16_mag(right_val)));

                        assign node_val[DST + n] = left_wins ? left_val : right_val;
                        assign node_idx[DST + n] = left_wins ? node_idx[SRC + 2*n]
                                                             : node_idx[SRC + 2*n + 1];
                end
        end

        // Root
        assign o_max       = node_val[NUM_NODES-1];
        assign o_max_index = node_idx[NUM_NODES-1];

        // ----------------------------------------
        // Checks
        // ----------------------------------------

        // No element beats the winner and no lower index ties it
        always_comb begin
                max_is_bound = 1'b1;
                for (int i = 0; i < NUM_ELEMS; i++) begin
                        if (bf16_is_nan(o_max)) begin
                                // An earlier NaN would have won
                                if ((i < int'(o_max_index)) && bf16_is_nan(i_values[i]))
                                        max_is_bound = 1'b0;
                        end else if (bf16_is_nan(i_values[i]) ||
                                     (bf16_mag(i_values[i]) > bf16_mag(o_max)) ||
                                     ((i < int'(o_max_index)) &&
                                      (bf16_mag(i_values[i]) == bf16_mag(o_max)))) begin
                                max_is_bound = 1'b0;
                        end
                end
        end

        // Index in range, on the winner, and the winner is the true maximum
        always_comb begin
                assert final ($isunknown(i_values) ||
                              ((int'(o_max_index) < NUM_ELEMS) &&
                               (i_values[o_max_index] == o_max) &&
                               max_is_bound))
                else $error("max index %0d is not the largest element", o_max_index);
        end

endmodule : bf16_max_tree

// File: design/block_exponent_stage.sv
// ----------------------------------------
// Shared exponent stage
// Captures the block, reduces it through
// the max tree and registers the shared
// exponent, flags, index and the block
// ----------------------------------------
`timescale 1ns/10ps

module block_exponent_stage
        import bfq_pkg::*;
#(
        parameter  int NUM_ELEMS = 8,
        localparam int IDX_W     = $clog2(NUM_ELEMS)
) (
        input  logic                  i_clk,
        input  logic                  i_arst_n,
        input  logic                  i_valid,
        input  bf16_t [NUM_ELEMS-1:0] i_block,
        output logic                  o_valid,
        output bf16_t [NUM_ELEMS-1:0] o_block,
        output block_info_t           o_info,
        output logic [IDX_W-1:0]      o_max_index
);

        // Captured input
        logic                  cap_valid;
        bf16_t [NUM_ELEMS-1:0] cap_block;

        // Tree result
        bf16_t                 tree_max;
        logic [IDX_W-1:0]      tree_index;
        logic                  tree_all_zero;
        block_info_t           tree_info;

        // ----------------------------------------
        // Edge 1, input capture
        // ----------------------------------------
        always_ff @(posedge i_clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        cap_valid <= 1'b0;
                end else begin
                        cap_valid <= i_valid;
                end
        end

        // Payload only moves with a strobe
        always_ff @(posedge i_clk) begin
                if (i_valid) begin
                        cap_block <= i_block;
                end
        end

        // ----------------------------------------
        // Max reduction
        // ----------------------------------------
        bf16_max_tree #(
                .NUM_ELEMS   (NUM_ELEMS)
        ) u_max_tree (
                .i_values    (cap_block),
                .o_max       (tree_max),
                .o_max_index (tree_index),
                .o_all_zero  (tree_all_zero)
        );

        // Winner exponent becomes the block exponent
        // Infinity lands here as 255 with no NaN flag
        always_comb begin
                tree_info.shared_exp = tree_max[14:7];
                tree_info.all_zero   = tree_all_zero;
                // NaN anywhere always wins the tree
                tree_info.has_nan    = bf16_is_nan(tree_max);
        end

        // ----------------------------------------
        // Edge 2, result registers
        // ----------------------------------------
        always_ff @(posedge i_clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        o_valid <= 1'b0;
                end else begin
                        o_valid <= cap_valid;
                end
        end

        always_ff @(posedge i_clk) begin
                if (cap_valid) begin
                        o_block     <= cap_block;
                        o_info      <= tree_info;
                        o_max_index <= tree_index;
                end
        end

        // All-zero block must come out with exponent 0
        a_zero_exp: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                o_valid && o_info.all_zero |-> o_info.shared_exp == 8'h00)
        else $error("all_zero set with shared exponent %0d", o_info.shared_exp);

endmodule : block_exponent_stage

// File: design/block_quant/block_quant_stage.sv
// ----------------------------------------
// Block quantization stage
// One element quantizer per lane, then a
// single register stage for the INT8
// block, its info and the max index
// ----------------------------------------
`timescale 1ns/10ps

module block_quant_stage
        import bfq_pkg::*;
#(
        parameter  int NUM_ELEMS = 8,
        localparam int IDX_W     = $clog2(NUM_ELEMS)
) (
        input  logic                    i_clk,
        input  logic                    i_arst_n,
        input  logic                    i_valid,
        input  bf16_t [NUM_ELEMS-1:0]   i_block,
        input  block_info_t             i_info,
        input  logic [IDX_W-1:0]        i_max_index,
        output logic                    o_valid,
        output q_elem_t [NUM_ELEMS-1:0] o_q_block,
        output block_info_t             o_info,
        output logic [IDX_W-1:0]        o_max_index
);

        q_elem_t [NUM_ELEMS-1:0] q_lane;

        // Per-lane check, element not above block exponent
        logic [NUM_ELEMS-1:0]    exp_in_range;

        // ----------------------------------------
        // Lanes
        // ----------------------------------------
        for (genvar k = 0; k < NUM_ELEMS; k++) begin : gen_lane
                element_quantizer u_quant (
                        .i_elem       (i_block[k]),
                        .i_shared_exp (i_info.shared_exp),
                        .o_q          (q_lane[k])
                );

                assign exp_in_range[k] = i_block[k][14:7] <= i_info.shared_exp;
        end

        // ----------------------------------------
        // Edge 3, output registers
        // ----------------------------------------
        always_ff @(posedge i_clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        o_valid <= 1'b0;
                end else begin
                        o_valid <= i_valid;
                end
        end

        always_ff @(posedge i_clk) begin
                if (i_valid) begin
                        // NaN poisons the whole block to zero
                        o_q_block   <= i_info.has_nan ? '0 : q_lane;
                        o_info      <= i_info;
                        o_max_index <= i_max_index;
                end
        end

        // Tree max must bound every lane of a clean block
        a_exp_bound: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                i_valid && !i_info.has_nan |-> &exp_in_range)
        else $error("element exponent above shared exponent %0d", i_info.shared_exp);

endmodule : block_quant_stage

// File: design/block_quant/element_quantizer.sv
// ----------------------------------------
// BF16 to INT8 element quantizer
// Aligns one element to the shared
// exponent by right shift, truncates,
// then applies the sign
// ----------------------------------------
`timescale 1ns/10ps

module element_quantizer
        import bfq_pkg::*;
(
        input  bf16_t     i_elem,
        input  bf16_exp_t i_shared_exp,
        output q_elem_t   o_q
);

        bf16_exp_t  elem_exp;
        bf16_exp_t  shift;
        logic [6:0] mag;
        logic [6:0] mag_aligned;
        q_elem_t    mag_signed;

        assign elem_exp = i_elem[14:7];

        // Distance below the block exponent
        // Wraps large if the element sits above it, which then flushes to 0
        assign shift = i_shared_exp - elem_exp;

        // Hidden one plus top six mantissa bits
        // Lowest mantissa bit is dropped
        assign mag = {1'b1, i_elem[6:1]};

        // ----------------------------------------
        // Alignment
        // ----------------------------------------
        always_comb begin
                if (bf16_is_zero(i_elem)) begin
                        // Zero and subnormal
                        mag_aligned = '0;
                end else if (shift >= 8'd7) begin
                        // Shifted fully out
                        mag_aligned = '0;
                end else begin
                        // Truncating shift
                        mag_aligned = mag >> shift[2:0];
                end
        end

        // At most 127, so the negation always fits
        assign mag_signed = q_elem_t'({1'b0, mag_aligned});

        // Sign
        assign o_q = i_elem[15] ? -mag_signed : mag_signed;

endmodule : element_quantizer

// File: sources.f
+incdir+tb
common/bfq_pkg.sv
design/bf16_max_tree/bf16_max_tree.sv
design/block_exponent_stage.sv
design/block_quant/element_quantizer.sv
design/block_quant/block_quant_stage.sv
design/bf16_block_quantizer.sv
tb/tb_bf16_block_quantizer.sv

// File: tb/tb_bfq_ref.svh
// ----------------------------------------
// Reference model for the block quantizer
// Expected max index, block info and INT8
// values worked out from the BF16 fields
// ----------------------------------------
`ifndef TB_BFQ_REF_SVH
`define TB_BFQ_REF_SVH

// Exponent all ones, mantissa not zero
function automatic logic ref_is_nan(input bf16_t v);
        return (v[14:7] == 8'd255) && (v[6:0] != 7'd0);
endfunction

// Lowest NaN wins, else largest magnitude, ties to lowest index
function automatic int ref_max_index(input block_t blk);
        int best;
        best = 0;
        for (int i = 1; i < NUM_ELEMS; i++) begin
                if (!ref_is_nan(blk[best])) begin
                        if (ref_is_nan(blk[i]) || (blk[i][14:0] > blk[best][14:0]))
                                best = i;
                end
        end
        return best;
endfunction

function automatic block_info_t ref_info(input block_t blk);
        block_info_t info;
        info.shared_exp = blk[ref_max_index(blk)][14:7];
        info.all_zero   = 1'b1;
        info.has_nan    = 1'b0;
        for (int i = 0; i < NUM_ELEMS; i++) begin
                if (blk[i][14:7] != 8'd0)
                        info.all_zero = 1'b0;
                if (ref_is_nan(blk[i]))
                        info.has_nan = 1'b1;
        end
        return info;
endfunction

// Hidden one and top six mantissa bits, truncating shift, then sign
function automatic q_elem_t ref_quant(input bf16_t v, input bf16_exp_t sexp);
        int shift;
        int mag;
        if (v[14:7] == 8'd0)
                return 8'sd0;
        shift = int'(sexp) - int'(v[14:7]);
        if (shift < 0 || shift >= 7)
                return 8'sd0;
        mag = (64 + int'(v[6:1])) >> shift;
        return q_elem_t'(v[15] ? -mag : mag);
endfunction

function automatic qblock_t ref_q_block(input block_t blk, input block_info_t info);
        qblock_t q;
        q = '0;
        // A NaN anywhere clears the whole block
        if (!info.has_nan) begin
                for (int i = 0; i < NUM_ELEMS; i++)
                        q[i] = ref_quant(blk[i], info.shared_exp);
        end
        return q;
endfunction

`endif

// File: tb/tb_bf16_block_quantizer.sv
// ----------------------------------------
// Testbench for the BF16 block quantizer
// Random, tie, NaN, zero and infinity
// blocks, single and back to back, checked
// by assertions against a reference queue
// ----------------------------------------
`timescale 1ns/10ps

module tb_bf16_block_quantizer
        import bfq_pkg::*;
;
        localparam int NUM_ELEMS    = 8;
        localparam int IDX_W        = $clog2(NUM_ELEMS);
        localparam int CLK_PERIOD   = 40;
        localparam int RESET_CYCLES = 16;
        localparam int N_SINGLE     = 6;
        localparam int N_BURST      = 24;
        localparam int N_TIE        = 8;
        localparam int N_NAN        = 6;
        localparam int N_ZERO       = 4;
        localparam int N_INF        = 2;
        localparam int N_BLOCKS     = N_SINGLE + N_BURST + N_TIE + N_NAN + N_ZERO + N_INF;
        // Up to 8 cycles per block when drained one at a time
        localparam int WATCHDOG_NS  = (RESET_CYCLES + 8*N_BLOCKS + 100) * CLK_PERIOD;

        typedef bf16_t   [NUM_ELEMS-1:0] block_t;
        typedef q_elem_t [NUM_ELEMS-1:0] qblock_t;

        // One pending block and what it should produce
        typedef struct {
                string            name;
                block_info_t      info;
                logic [IDX_W-1:0] idx;
                qblock_t          q;
        } expect_t;

        `include "tb_bfq_ref.svh"

        logic             i_clk;
        logic             i_arst_n;
        logic             i_valid;
        block_t           i_block;
        logic             o_valid;
        qblock_t          o_q_block;
        block_info_t      o_info;
        logic [IDX_W-1:0] o_max_index;

        expect_t          exp_q[$];
        string            head_name;
        block_info_t      head_info;
        logic [IDX_W-1:0] head_idx;
        qblock_t          head_q;
        int               sent_count = 0;
        int               recv_count = 0;
        integer           seed = 32'h6117_af59;

        bf16_block_quantizer #(
                .NUM_ELEMS   (NUM_ELEMS)
        ) dut0 (
                .i_clk       (i_clk),
                .i_arst_n    (i_arst_n),
                .i_valid     (i_valid),
                .i_block     (i_block),
                .o_valid     (o_valid),
                .o_q_block   (o_q_block),
                .o_info      (o_info),
                .o_max_index (o_max_index)
        );

        initial begin
                i_clk = 1'b0;
                forever #(CLK_PERIOD/2) i_clk = ~i_clk;
        end

        task automatic stop_on_error();
                $display("Result: FAILED");
                $fatal(1, "stopped at first error");
        endtask

        // ----------------------------------------
        // Block builders
        // ----------------------------------------

        // Exponent up to 10 below top so some shifts reach 7 and more
        function automatic bf16_t rand_elem(input int top);
                int e;
                e = top - int'($unsigned($random(seed)) % 11);
                if (e < 0)
                        e = 0;
                return {1'($random(seed)), 8'(e), 7'($random(seed))};
        endfunction

        function automatic block_t random_block(input int top);
                block_t blk;
                for (int i = 0; i < NUM_ELEMS; i++)
                        blk[i] = rand_elem(top);
                return blk;
        endfunction

        function automatic int rand_top();
                return 1 + int'($unsigned($random(seed)) % 254);
        endfunction

        // Same magnitude twice with opposite signs above all others
        function automatic block_t tie_block();
                block_t blk;
                bf16_t  peak;
                int     a;
                int     b;
                blk  = random_block(200);
                peak = {1'b0, 8'd210, 7'($random(seed))};
                a    = int'($unsigned($random(seed)) % (NUM_ELEMS - 1));
                b    = a + 1 + int'($unsigned($random(seed)) % (NUM_ELEMS - 1 - a));
                blk[a] = peak | 16'h8000;
                blk[b] = peak;
                return blk;
        endfunction

        // One or two NaNs in distinct lanes
        function automatic block_t nan_block();
                block_t blk;
                int     p;
                int     cnt;
                blk = random_block(rand_top());
                cnt = 1 + int'($unsigned($random(seed)) % 2);
                p   = int'($unsigned($random(seed)) % NUM_ELEMS);
                for (int k = 0; k < cnt; k++) begin
                        blk[p] = {1'($random(seed)), 8'hff, 7'($random(seed)) | 7'h01};
                        p = (p + 1 + int'($unsigned($random(seed)) % (NUM_ELEMS - 1)))
                            % NUM_ELEMS;
                end
                return blk;
        endfunction

        // Zeros and subnormals only
        function automatic block_t zero_block();
                block_t blk;
                for (int i = 0; i < NUM_ELEMS; i++)
                        blk[i] = {1'($random(seed)), 8'h00, 7'($random(seed))};
                return blk;
        endfunction

        function automatic block_t inf_block();
                block_t blk;
                blk = random_block(254);
                blk[$unsigned($random(seed)) % NUM_ELEMS] = {1'($random(seed)), 8'hff, 7'h00};
                return blk;
        endfunction

        // ----------------------------------------
        // Driving
        // ----------------------------------------
        task automatic send_block(input block_t blk, input string name);
                expect_t e;
                @(negedge i_clk);
                i_valid = 1'b1;
                i_block = blk;
                e.name  = name;
                e.info  = ref_info(blk);
                e.idx   = IDX_W'(ref_max_index(blk));
                e.q     = ref_q_block(blk, e.info);
                exp_q.push_back(e);
                sent_count++;
        endtask

        // Watchdog bounds this wait
        task automatic end_burst_and_drain();
                @(negedge i_clk);
                i_valid = 1'b0;
                while (exp_q.size() != 0)
                        @(negedge i_clk);
        endtask

        // ----------------------------------------
        // Scoreboard and checks
        // ----------------------------------------

        // Head of queue is ready for the next rising edge
        always @(negedge i_clk) begin
                if (i_arst_n && o_valid) begin
                        if (exp_q.size() == 0) begin
                                $display("Output appeared with no block pending");
                                stop_on_error();
                        end else begin
                                head_name = exp_q[0].name;
                                head_info = exp_q[0].info;
                                head_idx  = exp_q[0].idx;
                                head_q    = exp_q[0].q;
                                void'(exp_q.pop_front());
                                recv_count++;
                        end
                end
        end

        a_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                i_valid |-> ##3 o_valid)
        else begin
                $display("Fail latency: o_valid expected 1 actual 0");
                stop_on_error();
        end

        a_no_extra: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                o_valid |-> $past(i_valid, 3))
        else begin
                $display("o_valid high without a block taken 3 cycles earlier");
                stop_on_error();
        end

        a_info: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                o_valid |-> o_info == head_info)
        else begin
                $display("Fail %s: info expected %h actual %h",
                         head_name, head_info, $sampled(o_info));
                stop_on_error();
        end

        a_index: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                o_valid |-> o_max_index == head_idx)
        else begin
                $display("Fail %s: max index expected %0d actual %0d",
                         head_name, head_idx, $sampled(o_max_index));
                stop_on_error();
        end

        a_q_block: assert property (@(posedge i_clk) disable iff (!i_arst_n)
                o_valid |-> o_q_block == head_q)
        else begin
                $display("Fail %s: q block expected %h actual %h",
                         head_name, head_q, $sampled(o_q_block));
                stop_on_error();
        end

        initial begin
                #(WATCHDOG_NS);
                $display("Watchdog expired, the run hung waiting for outputs");
                stop_on_error();
        end

        // ----------------------------------------
        // Stimulus
        // ----------------------------------------
        initial begin
                i_arst_n = 1'b0;
                i_valid  = 1'b0;
                i_block  = '0;
                repeat (RESET_CYCLES) @(posedge i_clk);
                @(negedge i_clk);
                i_arst_n = 1'b1;
                assert (o_valid === 1'b0)
                else begin
                        $display("o_valid is not low after reset");
                        stop_on_error();
                end

                // One block at a time
                for (int n = 0; n < N_SINGLE; n++) begin
                        send_block(random_block(rand_top()), "single");
                        end_burst_and_drain();
                end

                // Strobes on consecutive cycles
                for (int n = 0; n < N_BURST; n++)
                        send_block(random_block(rand_top()), "back_to_back");
                end_burst_and_drain();

                for (int n = 0; n < N_TIE; n++)
                        send_block(tie_block(), "tie");
                end_burst_and_drain();

                for (int n = 0; n < N_NAN; n++)
                        send_block(nan_block(), "nan");
                end_burst_and_drain();

                for (int n = 0; n < N_ZERO; n++)
                        send_block(zero_block(), "zero");
                end_burst_and_drain();

                for (int n = 0; n < N_INF; n++)
                        send_block(inf_block(), "infinity");
                end_burst_and_drain();

                // Let the last checks fire
                repeat (4) @(negedge i_clk);
                if (recv_count == sent_count && exp_q.size() == 0) begin
                        $display("Result: PASSED");
                        $finish;
                end else begin
                        $display("Fail count: outputs expected %0d actual %0d",
                                 sent_count, recv_count);
                        stop_on_error();
                end
        end

endmodule : tb_bf16_block_quantizer
